// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - source/fabric_pkg.sv
  - source/reset_stretch.sv
  - source/addr_decoder.sv
  - source/tcm_bank.sv
  - source/resp_merge.sv
  - source/irq_conditioner.sv
  - source/soc_fabric.sv
  - target: test
    files:
      - tests/soc_fabric_checker.sv
      - tests/soc_fabric_tb.sv

// ==== soc_fabric.f ====
source/fabric_pkg.sv
source/reset_stretch.sv
source/addr_decoder.sv
source/tcm_bank.sv
source/resp_merge.sv
source/irq_conditioner.sv
source/soc_fabric.sv
tests/soc_fabric_checker.sv
tests/soc_fabric_tb.sv

// ==== source/addr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module addr_decoder
    import fabric_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      mem_valid_i,
    input  addr_t     mem_addr_i,
    output bank_sel_t bank_sel_o,
    output logic      err_ready_o
);

    logic [7:0] region;
    bank_sel_t  sel;
    logic       unmapped;
    logic       err_q;

    assign region = mem_addr_i[ADDR_W-1 -: 8];  // top address byte

    always_comb
    begin
        for (int i = 0; i < NUM_BANKS; i++)
        begin
            sel[i] = mem_valid_i && (region == REGION_BASE[i]);
        end
    end

    // valid request that hits no bank
    assign unmapped = mem_valid_i && !(|sel);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            err_q <= 1'b0;
        end
        else
        begin
            err_q <= unmapped && !err_q;  // no repeat while master still holds valid
        end
    end

    assign bank_sel_o  = sel;
    assign err_ready_o = err_q;

endmodule

`default_nettype wire

// ==== source/fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int IRQ_W  = 32;

    // tcm geometry
    localparam int NUM_BANKS  = 2;
    localparam int BANK_WORDS = 256;
    localparam int BANK_AW    = $clog2(BANK_WORDS);  // word index from addr[9:2]

    // top address byte per bank, everything else is unmapped
    localparam logic [7:0] REGION_BASE [NUM_BANKS] = '{
        8'h01,  // data tcm
        8'h02   // instruction tcm
    };

    // power-on reset length in clocks
    localparam int RST_STRETCH = 16;

    // interrupt conditioning
    localparam int             DBG_IRQ_BIT   = 4;
    localparam logic [IRQ_W-1:0] IRQ_ZERO_MASK = 32'h0000_002f;  // bits 5 and 3..0

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [STRB_W-1:0]    strb_t;
    typedef logic [BANK_AW-1:0]   bank_idx_t;
    typedef logic [NUM_BANKS-1:0] bank_sel_t;
    typedef logic [IRQ_W-1:0]     irq_t;

endpackage

`default_nettype wire

// ==== source/irq_conditioner.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_conditioner
    import fabric_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  irq_t irq_i,
    input  irq_t irq_mask_i,
    output irq_t irq_o
);

    irq_t       irq_q;
    logic [2:0] dbg_sr;  // extra stages on the debug line
    irq_t       irq_c;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            irq_q  <= '0;
            dbg_sr <= '0;
        end
        else
        begin
            irq_q  <= irq_i & ~irq_mask_i;
            dbg_sr <= {dbg_sr[1:0], irq_q[DBG_IRQ_BIT]};
        end
    end

    always_comb
    begin
        irq_c = irq_q & ~IRQ_ZERO_MASK;
        // rising edge of the debug line, one cycle wide
        irq_c[DBG_IRQ_BIT] = dbg_sr[1] & ~dbg_sr[2];
    end

    assign irq_o = irq_c;

endmodule

`default_nettype wire

// ==== source/reset_stretch.sv ====
`timescale 1ns/1ns
`default_nettype none

module reset_stretch #(
    parameter int STAGES = 16
) (
    input  logic clk,
    input  logic resetn,
    output logic resetn_o
);

    logic [STAGES-1:0] sr;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sr <= '0;
        end
        else
        begin
            sr <= {sr[STAGES-2:0], 1'b1};  // fill with ones
        end
    end

    // external reset still acts at once
    assign resetn_o = sr[STAGES-1] & resetn;

endmodule

`default_nettype wire

// ==== source/resp_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module resp_merge
    import fabric_pkg::*;
(
    input  bank_sel_t bank_ready_i,
    input  data_t     bank_rdata_i [NUM_BANKS],
    input  logic      err_ready_i,
    output logic      mem_ready_o,
    output data_t     mem_rdata_o,
    output logic      mem_err_o
);

    data_t rdata_or;

    // idle banks drive zero, so an OR picks the active one
    always_comb
    begin
        rdata_or = '0;
        for (int i = 0; i < NUM_BANKS; i++)
        begin
            rdata_or = rdata_or | bank_rdata_i[i];
        end
    end

    assign mem_ready_o = (|bank_ready_i) || err_ready_i;
    assign mem_rdata_o = rdata_or;  // error response carries zero data
    assign mem_err_o   = err_ready_i;

endmodule

`default_nettype wire

// ==== source/soc_fabric.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_fabric
    import fabric_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  mem_valid_i,
    input  addr_t mem_addr_i,
    input  data_t mem_wdata_i,
    input  strb_t mem_wstrb_i,
    input  irq_t  irq_i,
    input  irq_t  irq_mask_i,
    output logic  mem_ready_o,
    output data_t mem_rdata_o,
    output logic  mem_err_o,
    output irq_t  irq_o,
    output logic  sys_resetn_o
);

    logic      sys_resetn;
    bank_sel_t bank_sel;
    bank_sel_t bank_ready;
    data_t     bank_rdata [NUM_BANKS];
    logic      err_ready;
    bank_idx_t word_idx;

    assign word_idx = mem_addr_i[BANK_AW+1:2];  // aliases inside a region

    reset_stretch #(
        .STAGES   (RST_STRETCH)
    ) u_stretch (
        .clk      (clk),
        .resetn   (resetn),
        .resetn_o (sys_resetn)
    );

    addr_decoder u_dec (
        .clk         (clk),
        .resetn      (sys_resetn),
        .mem_valid_i (mem_valid_i),
        .mem_addr_i  (mem_addr_i),
        .bank_sel_o  (bank_sel),
        .err_ready_o (err_ready)
    );

    for (genvar i = 0; i < NUM_BANKS; i++)
    begin : g_bank
        tcm_bank u_bank (
            .clk     (clk),
            .resetn  (sys_resetn),
            .sel_i   (bank_sel[i]),
            .addr_i  (word_idx),
            .wdata_i (mem_wdata_i),
            .wstrb_i (mem_wstrb_i),
            .ready_o (bank_ready[i]),
            .rdata_o (bank_rdata[i])
        );
    end

    resp_merge u_merge (
        .bank_ready_i (bank_ready),
        .bank_rdata_i (bank_rdata),
        .err_ready_i  (err_ready),
        .mem_ready_o  (mem_ready_o),
        .mem_rdata_o  (mem_rdata_o),
        .mem_err_o    (mem_err_o)
    );

    irq_conditioner u_irq (
        .clk        (clk),
        .resetn     (sys_resetn),
        .irq_i      (irq_i),
        .irq_mask_i (irq_mask_i),
        .irq_o      (irq_o)
    );

    assign sys_resetn_o = sys_resetn;  // also for peripherals outside the fabric

endmodule

`default_nettype wire

// ==== source/tcm_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module tcm_bank
    import fabric_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      sel_i,
    input  bank_idx_t addr_i,
    input  data_t     wdata_i,
    input  strb_t     wstrb_i,
    output logic      ready_o,
    output data_t     rdata_o
);

    data_t mem [BANK_WORDS];
    data_t rdata_q;
    logic  ready_q;
    logic  take;

    // accept a select unless we answered on the last edge
    assign take = sel_i && !ready_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ready_q <= 1'b0;
        end
        else
        begin
            ready_q <= take;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (wstrb_i[b])
                begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
            rdata_q <= (|wstrb_i) ? '0 : mem[addr_i];  // writes return zero
        end
    end

    assign ready_o = ready_q;

    // zero when idle so the merger can simply OR
    assign rdata_o = ready_q ? rdata_q : '0;

endmodule

`default_nettype wire

// ==== tests/soc_fabric_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_checker
    import fabric_pkg::*;
(
    input logic  clk,
    input logic  resetn,
    input logic  sys_resetn_o,
    input logic  mem_valid_i,
    input logic  mem_ready_o,
    input data_t mem_rdata_o,
    input logic  mem_err_o,
    input irq_t  irq_o
);

    int fail_cnt = 0;

    ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        mem_ready_o |-> mem_valid_i)
    else
    begin
        $error("ready without a pending request");
        fail_cnt++;
    end

    ready_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        mem_ready_o |=> !mem_ready_o)
    else
    begin
        $error("ready high on two cycles in a row");
        fail_cnt++;
    end

    zero_irq_bits: assert property (@(posedge clk) disable iff (!resetn)
        (irq_o & IRQ_ZERO_MASK) == '0)
    else
    begin
        $error("forced interrupt bits not zero");
        fail_cnt++;
    end

    no_ready_in_reset: assert property (@(posedge clk) disable iff (!resetn)
        !sys_resetn_o |-> !mem_ready_o)
    else
    begin
        $error("ready while the system reset is low");
        fail_cnt++;
    end

    // error answers carry no bank data
    err_with_ready: assert property (@(posedge clk) disable iff (!resetn)
        mem_err_o |-> mem_ready_o && mem_rdata_o == '0)
    else
    begin
        $error("error flag without ready or with nonzero data");
        fail_cnt++;
    end

endmodule

bind soc_fabric soc_fabric_checker u_checker (
    .clk          (clk),
    .resetn       (resetn),
    .sys_resetn_o (sys_resetn_o),
    .mem_valid_i  (mem_valid_i),
    .mem_ready_o  (mem_ready_o),
    .mem_rdata_o  (mem_rdata_o),
    .mem_err_o    (mem_err_o),
    .irq_o        (irq_o)
);

`default_nettype wire

// ==== tests/soc_fabric_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_tb
    import fabric_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = 4000;  // tests need well under 2000
    localparam int MAX_WAIT        = 32;

    logic  clk;
    logic  resetn;
    logic  mem_valid_i;
    addr_t mem_addr_i;
    data_t mem_wdata_i;
    strb_t mem_wstrb_i;
    irq_t  irq_i;
    irq_t  irq_mask_i;
    logic  mem_ready_o;
    data_t mem_rdata_o;
    logic  mem_err_o;
    irq_t  irq_o;
    logic  sys_resetn_o;

    int    errors;
    data_t model [NUM_BANKS][BANK_WORDS];  // per-bank reference contents
    data_t rsp_data;
    logic  rsp_err;
    int    rsp_edges;

    soc_fabric UUT (
        .clk          (clk),
        .resetn       (resetn),
        .mem_valid_i  (mem_valid_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_wstrb_i  (mem_wstrb_i),
        .irq_i        (irq_i),
        .irq_mask_i   (irq_mask_i),
        .mem_ready_o  (mem_ready_o),
        .mem_rdata_o  (mem_rdata_o),
        .mem_err_o    (mem_err_o),
        .irq_o        (irq_o),
        .sys_resetn_o (sys_resetn_o)
    );

    function automatic addr_t make_addr(input logic [7:0] region, input bank_idx_t idx,
                                        input logic [13:0] high);
        return {region, high, idx, 2'b00};  // bits 23:10 alias inside a region
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t res;
        res = old_word;
        for (int b = 0; b < STRB_W; b++)
        begin
            if (strb[b])
            begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    // one request, held until ready is seen
    task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t strb);
        int waited;
        waited    = 0;
        rsp_edges = 0;
        @(negedge clk);
        mem_valid_i = 1'b1;
        mem_addr_i  = addr;
        mem_wdata_i = wdata;
        mem_wstrb_i = strb;
        while (rsp_edges == 0 && waited < MAX_WAIT)
        begin
            @(negedge clk);
            waited++;
            if (mem_ready_o)
            begin
                rsp_edges = waited + 1;  // sampled on the next rising edge
                rsp_data  = mem_rdata_o;
                rsp_err   = mem_err_o;
            end
        end
        if (rsp_edges != 0)
        begin
            @(negedge clk);  // keep the request through the edge that samples ready
        end
        mem_valid_i = 1'b0;
        mem_wstrb_i = '0;
        if (rsp_edges == 0)
        begin
            $display("Error: no ready for the access to address %h", addr);
            errors++;
        end
    endtask

    task automatic check_response(input string what, input data_t exp_data, input logic exp_err);
        if (rsp_edges != 0 && rsp_edges != 2)
        begin
            $display("Error: mem_ready_o came on edge %0d instead of edge 2 (%s)", rsp_edges, what);
            errors++;
        end
        if (rsp_edges != 0 && rsp_data !== exp_data)
        begin
            $display("Error: mem_rdata_o = %h, expected %h (%s)", rsp_data, exp_data, what);
            errors++;
        end
        if (rsp_edges != 0 && rsp_err !== exp_err)
        begin
            $display("Error: mem_err_o = %h, expected %h (%s)", rsp_err, exp_err, what);
            errors++;
        end
    endtask

    task automatic check_reset_stretch();
        int   edges;
        int   waited;
        logic early;
        edges  = 0;
        waited = 0;
        early  = 1'b0;
        @(negedge clk);
        resetn      = 1'b1;
        mem_valid_i = 1'b1;  // read already pending during the stretch
        mem_addr_i  = make_addr(REGION_BASE[0], '0, '0);
        while (!sys_resetn_o && edges < MAX_WAIT)
        begin
            @(negedge clk);
            edges++;
            if (mem_ready_o && !sys_resetn_o)
            begin
                early = 1'b1;
            end
        end
        if (edges != RST_STRETCH)
        begin
            $display("Error: sys_resetn_o edge count = %h, expected %h", edges, RST_STRETCH);
            errors++;
        end
        if (early)
        begin
            $display("Error: ready was seen while the system reset was still low");
            errors++;
        end
        while (!mem_ready_o && waited < MAX_WAIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!mem_ready_o)
        begin
            $display("Error: the read issued during reset never got ready");
            errors++;
        end
        else
        begin
            @(negedge clk);  // past the edge that samples ready
        end
        mem_valid_i = 1'b0;
    endtask

    task automatic check_bank_rw();
        int        q_bank [$];
        int        q_idx [$];
        int        j;
        int        tmp;
        bank_idx_t idx;
        data_t     d;
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            for (int n = 0; n < 12; n++)
            begin
                idx = bank_idx_t'($urandom);
                d   = $urandom;
                bus_access(make_addr(REGION_BASE[b], idx, '0), d, 4'hf);
                check_response("full write", '0, 1'b0);
                model[b][idx] = d;
                q_bank.push_back(b);
                q_idx.push_back(idx);
            end
        end
        for (int i = q_bank.size() - 1; i > 0; i--)  // read back in shuffled order
        begin
            j         = $urandom % (i + 1);
            tmp       = q_bank[i];
            q_bank[i] = q_bank[j];
            q_bank[j] = tmp;
            tmp       = q_idx[i];
            q_idx[i]  = q_idx[j];
            q_idx[j]  = tmp;
        end
        for (int i = 0; i < q_bank.size(); i++)
        begin
            bus_access(make_addr(REGION_BASE[q_bank[i]], q_idx[i], '0), '0, '0);
            check_response("read back", model[q_bank[i]][q_idx[i]], 1'b0);
        end
    endtask

    task automatic check_strobes();
        int          b;
        int          other;
        bank_idx_t   idx;
        strb_t       strb;
        data_t       d;
        logic [13:0] high;
        for (int n = 0; n < 8; n++)
        begin
            b     = n % NUM_BANKS;
            other = (b + 1) % NUM_BANKS;
            idx   = bank_idx_t'($urandom);
            d     = $urandom;
            bus_access(make_addr(REGION_BASE[b], idx, '0), d, 4'hf);
            model[b][idx] = d;
            d = $urandom;
            bus_access(make_addr(REGION_BASE[other], idx, '0), d, 4'hf);
            model[other][idx] = d;
            strb = strb_t'($urandom % 15 + 1);  // never a read
            d    = $urandom;
            high = 14'($urandom % 16383 + 1);
            bus_access(make_addr(REGION_BASE[b], idx, high), d, strb);  // aliased address
            check_response("partial write", '0, 1'b0);
            model[b][idx] = merge_bytes(model[b][idx], d, strb);
            bus_access(make_addr(REGION_BASE[b], idx, '0), '0, '0);
            check_response("strobed word", model[b][idx], 1'b0);
            bus_access(make_addr(REGION_BASE[other], idx, ~high), '0, '0);
            check_response("other bank", model[other][idx], 1'b0);
        end
    endtask

    task automatic check_unmapped();
        logic [7:0] regions [3];
        logic [7:0] r;
        regions[0] = 8'h00;
        regions[1] = 8'h03;
        do
        begin
            r = 8'($urandom);
        end
        while (r == REGION_BASE[0] || r == REGION_BASE[1] || r == 8'h00 || r == 8'h03);
        regions[2] = r;
        for (int i = 0; i < 3; i++)
        begin
            bus_access({regions[i], 24'($urandom)}, $urandom, 4'hf);
            check_response("unmapped write", '0, 1'b1);
            bus_access({regions[i], 24'($urandom)}, '0, '0);
            check_response("unmapped read", '0, 1'b1);
        end
    endtask

    task automatic check_irq_lines();
        irq_t exp;
        for (int n = 0; n < 10; n++)
        begin
            @(negedge clk);
            irq_i      = $urandom;
            irq_mask_i = $urandom;
            exp        = irq_i & ~irq_mask_i;
            @(negedge clk);
            if (irq_o[IRQ_W-1:6] !== exp[IRQ_W-1:6])
            begin
                $display("Error: irq_o = %h, expected %h in bits above 5", irq_o, exp);
                errors++;
            end
            if ((irq_o & IRQ_ZERO_MASK) !== '0)
            begin
                $display("Error: irq_o = %h, expected zero in the forced bits", irq_o);
                errors++;
            end
        end
    endtask

    task automatic check_debug_pulse(input logic masked);
        logic exp;
        @(negedge clk);
        irq_i      = '0;
        irq_mask_i = masked ? (irq_t'(1) << DBG_IRQ_BIT) : '0;
        repeat (5) @(negedge clk);  // drain the edge detector
        irq_i[DBG_IRQ_BIT] = 1'b1;
        for (int k = 1; k <= 6; k++)
        begin
            @(negedge clk);
            exp = !masked && (k == 3);
            if (irq_o[DBG_IRQ_BIT] !== exp)
            begin
                $display("Error: irq_o[%0d] = %h after edge %0d, expected %h",
                         DBG_IRQ_BIT, irq_o[DBG_IRQ_BIT], k, exp);
                errors++;
            end
        end
        irq_i      = '0;
        irq_mask_i = '0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hb4b2a9f7));
        errors      = 0;
        resetn      = 1'b0;
        mem_valid_i = 1'b0;
        mem_addr_i  = '0;
        mem_wdata_i = '0;
        mem_wstrb_i = '0;
        irq_i       = '0;
        irq_mask_i  = '0;
        repeat (2) @(posedge clk);
        check_reset_stretch();
        check_bank_rw();
        check_strobes();
        check_unmapped();
        check_irq_lines();
        check_debug_pulse(1'b0);
        check_debug_pulse(1'b1);
        repeat (2) @(negedge clk);
        errors += UUT.u_checker.fail_cnt;  // failed assertions of the bound checker
        $display("Errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
